// File: filelist.f
+incdir+verilog
verilog/cdma_pkg.sv
verilog/cdma_burst_counter.sv
verilog/cdma_burst_queue.sv
verilog/cdma_rd_ctrl.sv
verilog/cdma_rd_top.sv
test/cdma_rd_chk.sv
test/cdma_rd_tb.sv

// File: Bender.yml
package:
  name: cdma_rd

export_include_dirs:
  - verilog

sources:
  # RTL, package first
  - include_dirs:
      - verilog
    files:
      - verilog/cdma_pkg.sv
      - verilog/cdma_burst_counter.sv
      - verilog/cdma_burst_queue.sv
      - verilog/cdma_rd_ctrl.sv
      - verilog/cdma_rd_top.sv
  # Testbench and bound checker
  - target: test
    include_dirs:
      - verilog
    files:
      - test/cdma_rd_chk.sv
      - test/cdma_rd_tb.sv

// File: test/cdma_rd_tb.sv
/*
 * Directed testbench for the aligned read engine
 * Memory model returns bursts in order, pattern {~addr, addr}
 * Pattern assumes 32-bit addresses on a 64-bit data bus
 */
`timescale 1ns/1ps
`include "cdma_consts.svh"

`default_nettype none

module cdma_rd_tb
  import cdma_pkg::*;
();

  localparam int CLK_PERIOD = 40;

  logic   aclk;
  logic   aresetn;
  logic   ctrl_valid;
  addr_t  ctrl_addr;
  len_t   ctrl_len;
  logic   ctrl_last;
  logic   stat_ready;
  logic   stat_done;
  logic   arvalid;
  addr_t  araddr;
  beats_t arlen;
  logic   arready;
  logic   rvalid;
  data_t  rdata;
  logic   rlast;
  logic   rready;
  logic   axis_out_tvalid;
  data_t  axis_out_tdata;
  keep_t  axis_out_tkeep;
  logic   axis_out_tlast;
  logic   axis_out_tready;

  // Recorded AR requests and stream beats
  addr_t  ar_addr_q[$];
  beats_t ar_len_q[$];
  data_t  rx_data_q[$];
  keep_t  rx_keep_q[$];
  logic   rx_last_q[$];
  logic   rx_done_q[$];

  int          err_count = 0;
  int          num_checks = 0;
  int          done_count = 0;
  int          in_flight = 0;
  logic [31:0] rand_state = 32'h18b7e0a9;
  logic        stall_on = 1'b0;
  int          mem_max_delay = 4;

  // Memory model read side
  int    serve_idx = 0;
  logic  r_active = 1'b0;
  addr_t r_addr = '0;
  int    r_left = 0;
  int    r_delay = 0;
  logic  beat_taken = 1'b0;

  cdma_rd_top DUT (.*);

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  ////////////////////////////////////////
  // Bus model, sample on rise, drive on fall
  ////////////////////////////////////////

  initial begin
    arready         = 1'b0;
    rvalid          = 1'b0;
    rdata           = '0;
    rlast           = 1'b0;
    axis_out_tready = 1'b0;
    forever begin
      @(posedge aclk);
      beat_taken = 1'b0;
      if (aresetn) begin
        if (arvalid && arready) begin
          ar_addr_q.push_back(araddr);
          ar_len_q.push_back(arlen);
          in_flight++;
        end
        // AXI read side beat, moves the memory model on
        if (rvalid && rready) begin
          beat_taken = 1'b1;
          if (rlast) in_flight--;
        end
        // Stream side beat, as the sink sees it
        if (axis_out_tvalid && axis_out_tready) begin
          rx_data_q.push_back(axis_out_tdata);
          rx_keep_q.push_back(axis_out_tkeep);
          rx_last_q.push_back(axis_out_tlast);
          rx_done_q.push_back(stat_done);
        end
        if (stat_done) done_count++;
        if (in_flight > `CDMA_MAX_OUTSTANDING) begin
          $display("more than %0d bursts in flight at %0t", `CDMA_MAX_OUTSTANDING, $time);
          err_count++;
        end
      end
      @(negedge aclk);
      // Roughly one cycle in three stalled when enabled
      arready         = stall_on ? (next_rand() % 3 != 0) : 1'b1;
      axis_out_tready = stall_on ? (next_rand() % 3 != 0) : 1'b1;
      if (beat_taken) begin
        if (r_left == 1) begin
          r_active = 1'b0;
          r_delay  = (mem_max_delay > 0) ? int'(next_rand() % mem_max_delay) : 0;
        end else begin
          r_left--;
          r_addr = r_addr + addr_t'(DATA_BYTES);
        end
      end
      // Next burst in address order once its latency runs out
      if (!r_active && serve_idx < ar_addr_q.size()) begin
        if (r_delay > 0) begin
          r_delay--;
        end else begin
          r_active = 1'b1;
          r_addr   = ar_addr_q[serve_idx];
          r_left   = int'(ar_len_q[serve_idx]) + 1;
          serve_idx++;
        end
      end
      rvalid = r_active;
      rlast  = r_active && (r_left == 1);
      rdata  = r_active ? {~r_addr, r_addr} : '0;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_addr(input string test, input string what, input addr_t exp,
                            input addr_t act);
    num_checks++;
    if (exp !== act) begin
      err_count++;
      $display("error %s %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic check_len(input string test, input string what, input beats_t exp,
                           input beats_t act);
    num_checks++;
    if (exp !== act) begin
      err_count++;
      $display("error %s %s expected %0d actual %0d", test, what, exp, act);
    end
  endtask

  task automatic check_data(input string test, input string what, input data_t exp,
                            input data_t act);
    num_checks++;
    if (exp !== act) begin
      err_count++;
      $display("error %s %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic check_keep(input string test, input string what, input keep_t exp,
                            input keep_t act);
    num_checks++;
    if (exp !== act) begin
      err_count++;
      $display("error %s %s expected %b actual %b", test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
                           input logic act);
    num_checks++;
    if (exp !== act) begin
      err_count++;
      $display("error %s %s expected %b actual %b", test, what, exp, act);
    end
  endtask

  task automatic check_num(input string test, input string what, input int exp, input int act);
    num_checks++;
    if (exp != act) begin
      err_count++;
      $display("error %s %s expected %0d actual %0d", test, what, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Command runner
  ////////////////////////////////////////

  task automatic run_command(input string test, input addr_t base, input len_t len,
                             input logic last);
    int     ar_base;
    int     rx_base;
    int     done_base;
    int     n_bursts;
    int     n_beats;
    int     rem;
    int     t;
    int     k;
    logic   seen;
    addr_t  beat_addr;
    beats_t exp_len;
    ar_base   = ar_addr_q.size();
    rx_base   = rx_data_q.size();
    done_base = done_count;
    n_beats   = len / DATA_BYTES;
    rem       = (len % BURST_BYTES) / DATA_BYTES;
    n_bursts  = len / BURST_BYTES + ((rem != 0) ? 1 : 0);
    @(negedge aclk);
    ctrl_valid = 1'b1;
    ctrl_addr  = base;
    ctrl_len   = len;
    ctrl_last  = last;
    // Taken on the first rising edge with stat_ready high
    seen = 1'b0;
    for (t = 0; t < 50 && !seen; t++) begin
      @(posedge aclk);
      seen = stat_ready;
    end
    @(negedge aclk);
    ctrl_valid = 1'b0;
    if (!seen) begin
      $display("%s: command was never accepted", test);
      err_count++;
      return;
    end
    for (t = 0; t < 20000 && (rx_data_q.size() - rx_base) < n_beats; t++) @(negedge aclk);
    if ((rx_data_q.size() - rx_base) < n_beats) begin
      $display("%s: timed out waiting for stream beats", test);
      err_count++;
    end
    seen = 1'b0;
    for (t = 0; t < 100 && !seen; t++) begin
      @(posedge aclk);
      seen = stat_ready;
    end
    if (!seen) begin
      $display("%s: stat_ready did not return high", test);
      err_count++;
    end
    // Settle, so stray beats or pulses get counted
    repeat (4) @(negedge aclk);
    check_num(test, "bursts", n_bursts, ar_addr_q.size() - ar_base);
    for (k = 0; k < n_bursts && ar_base + k < ar_addr_q.size(); k++) begin
      check_addr(test, "araddr", base + addr_t'(k * BURST_BYTES), ar_addr_q[ar_base + k]);
      if (k == n_bursts - 1 && rem != 0) begin
        exp_len = beats_t'(rem - 1);
      end else begin
        exp_len = beats_t'(`CDMA_BURST_LEN - 1);
      end
      check_len(test, "arlen", exp_len, ar_len_q[ar_base + k]);
    end
    check_num(test, "beats", n_beats, rx_data_q.size() - rx_base);
    for (k = 0; k < n_beats && rx_base + k < rx_data_q.size(); k++) begin
      beat_addr = base + addr_t'(k * DATA_BYTES);
      check_data(test, "tdata", {~beat_addr, beat_addr}, rx_data_q[rx_base + k]);
      // Full beats only, every byte lane kept
      check_keep(test, "tkeep", '1, rx_keep_q[rx_base + k]);
      check_bit(test, "tlast", last && (k == n_beats - 1), rx_last_q[rx_base + k]);
      check_bit(test, "stat_done", last && (k == n_beats - 1), rx_done_q[rx_base + k]);
    end
    check_num(test, "stat_done pulses", last ? 1 : 0, done_count - done_base);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic single_full_burst();
    run_command("single_burst", 32'h0000_1000, 128, 1'b1);
  endtask

  task automatic short_final_burst();
    run_command("short_burst", 32'h0000_2040, 40, 1'b1);
  endtask

  task automatic multi_burst_split();
    run_command("multi_burst", 32'h0001_0000, 408, 1'b1);
  endtask

  // Flag clear, then a second command must still go through
  task automatic flag_clear_then_next();
    run_command("no_last", 32'h0002_0000, 256, 1'b0);
    run_command("no_last_next", 32'h0002_8000, 64, 1'b1);
  endtask

  // Sixteen bursts against a slow memory fill the outstanding queue
  task automatic stalls_slow_memory();
    @(posedge aclk);
    stall_on      = 1'b1;
    mem_max_delay = 16;
    run_command("stalls", 32'h0004_0000, 2048, 1'b1);
    @(posedge aclk);
    stall_on      = 1'b0;
    mem_max_delay = 4;
  endtask

  initial begin
    aresetn    = 1'b0;
    ctrl_valid = 1'b0;
    ctrl_addr  = '0;
    ctrl_len   = '0;
    ctrl_last  = 1'b0;
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    single_full_burst();
    short_final_burst();
    multi_burst_split();
    flag_clear_then_next();
    stalls_slow_memory();
    repeat (2) @(negedge aclk);
    $display("checks %0d, errors %0d, assertion failures %0d",
             num_checks, err_count, DUT.u_chk.fail_count);
    if (err_count == 0 && DUT.u_chk.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/cdma_rd_chk.sv
/*
 * Protocol assertions bound into the read engine top
 * Covers the AR hold rule, reset state and the status strobes
 * fail_count is read hierarchically at the end of a run
 */
`timescale 1ns/1ps
`include "cdma_consts.svh"

`default_nettype none

module cdma_rd_chk
  import cdma_pkg::*;
(
  input wire    aclk,
  input wire    aresetn,
  input wire    arvalid,
  input wire    arready,
  input addr_t  araddr,
  input beats_t arlen,
  input wire    stat_ready,
  input wire    stat_done,
  input wire    rvalid,
  input wire    rready,
  input wire    rlast
);

  // Failed assertions so far
  int fail_count = 0;

  // AR quiet while reset is applied and on the first cycle out
  a_ar_reset: assert property (@(posedge aclk) !aresetn |=> !arvalid)
    else begin
      fail_count++;
      $error("arvalid high during or right after reset");
    end

  // Address and length hold until the slave takes them
  a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
      fail_count++;
      $error("AR channel changed before arready");
    end

  // No new command while bursts are still being issued
  a_ready_busy: assert property (@(posedge aclk) disable iff (!aresetn)
      arvalid |-> !stat_ready)
    else begin
      fail_count++;
      $error("stat_ready high while arvalid is high");
    end

  // Done only on a taken rlast beat
  a_done_beat: assert property (@(posedge aclk) disable iff (!aresetn)
      stat_done |-> rvalid && rready && rlast)
    else begin
      fail_count++;
      $error("stat_done without a handshaked rlast beat");
    end

endmodule

bind cdma_rd_top cdma_rd_chk u_chk (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .arvalid    (arvalid),
  .arready    (arready),
  .araddr     (araddr),
  .arlen      (arlen),
  .stat_ready (stat_ready),
  .stat_done  (stat_done),
  .rvalid     (rvalid),
  .rready     (rready),
  .rlast      (rlast)
);

`default_nettype wire

// File: verilog/cdma_rd_top.sv
/*
 * Aligned read engine, AXI4 read to AXI4-Stream
 * Fixed AR attributes, IDs and responses live outside this block
 * Byte strobes are not generated; tkeep is always full
 */
`timescale 1ns/1ps
`include "cdma_consts.svh"

`default_nettype none

module cdma_rd_top
  import cdma_pkg::*;
(
  input  wire    aclk,
  input  wire    aresetn,
  // Command and status
  input  wire    ctrl_valid,
  input  addr_t  ctrl_addr,
  input  len_t   ctrl_len,
  input  wire    ctrl_last,
  output logic   stat_ready,
  output logic   stat_done,
  // AXI read address
  output logic   arvalid,
  output addr_t  araddr,
  output beats_t arlen,
  input  wire    arready,
  // AXI read data
  input  wire    rvalid,
  input  data_t  rdata,
  input  wire    rlast,
  output logic   rready,
  // Stream out
  output logic   axis_out_tvalid,
  output data_t  axis_out_tdata,
  output keep_t  axis_out_tkeep,
  output logic   axis_out_tlast,
  input  wire    axis_out_tready
);

  // Control to counter
  logic       cnt_load;
  burst_cnt_t cnt_value;
  logic       cnt_decr;
  logic       cnt_zero;

  // Control to queue
  logic       q_push;
  logic       q_flag;
  logic       q_pop;
  logic       q_full;
  logic       q_head;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  cdma_rd_ctrl u_ctrl (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .ctrl_valid      (ctrl_valid),
    .ctrl_addr       (ctrl_addr),
    .ctrl_len        (ctrl_len),
    .ctrl_last       (ctrl_last),
    .stat_ready      (stat_ready),
    .stat_done       (stat_done),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arlen           (arlen),
    .arready         (arready),
    .rvalid          (rvalid),
    .rlast           (rlast),
    .axis_out_tready (axis_out_tready),
    .rready          (rready),
    .axis_out_tvalid (axis_out_tvalid),
    .axis_out_tlast  (axis_out_tlast),
    .axis_out_tkeep  (axis_out_tkeep),
    .cnt_load        (cnt_load),
    .cnt_value       (cnt_value),
    .cnt_decr        (cnt_decr),
    .cnt_zero        (cnt_zero),
    .q_push          (q_push),
    .q_flag          (q_flag),
    .q_pop           (q_pop),
    .q_full          (q_full),
    .q_head          (q_head)
  );

  // Bursts left to issue
  cdma_burst_counter u_counter (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .load       (cnt_load),
    .load_value (cnt_value),
    .decr       (cnt_decr),
    .is_zero    (cnt_zero)
  );

  // End flags of bursts in flight
  cdma_burst_queue u_queue (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (q_push),
    .push_flag (q_flag),
    .pop       (q_pop),
    .full      (q_full),
    .head      (q_head)
  );

  // Data passes straight through
  assign axis_out_tdata = rdata;

endmodule

`default_nettype wire

// File: verilog/cdma_rd_ctrl.sv
/*
 * Control for the aligned read engine
 * Address must be beat aligned, length a nonzero multiple of the beat
 * No 4 KB split; bursts simply step by a full burst size
 * Stream ready feeds rready directly, no buffering
 */
`timescale 1ns/1ps
`include "cdma_consts.svh"

`default_nettype none

module cdma_rd_ctrl
  import cdma_pkg::*;
(
  input  wire        aclk,
  input  wire        aresetn,
  // Command and status
  input  wire        ctrl_valid,
  input  addr_t      ctrl_addr,
  input  len_t       ctrl_len,
  input  wire        ctrl_last,
  output logic       stat_ready,
  output logic       stat_done,
  // AXI read address
  output logic       arvalid,
  output addr_t      araddr,
  output beats_t     arlen,
  input  wire        arready,
  // AXI read data and stream
  input  wire        rvalid,
  input  wire        rlast,
  input  wire        axis_out_tready,
  output logic       rready,
  output logic       axis_out_tvalid,
  output logic       axis_out_tlast,
  output keep_t      axis_out_tkeep,
  // Burst counter
  output logic       cnt_load,
  output burst_cnt_t cnt_value,
  output logic       cnt_decr,
  input  wire        cnt_zero,
  // End-flag queue
  output logic       q_push,
  output logic       q_flag,
  output logic       q_pop,
  input  wire        q_full,
  input  wire        q_head
);

  ar_state_t  state;
  logic       accept;
  logic       arxfer;
  logic       rxfer;
  logic       start_r;
  logic       last_r;
  addr_t      addr_r;
  beats_t     final_len_r;
  burst_cnt_t final_idx_r;
  burst_cnt_t full_bursts;
  logic [LOG_BURST_LEN-1:0] rem_beats;
  logic       has_rem;

  ////////////////////////////////////////
  // Command acceptance
  ////////////////////////////////////////

  assign stat_ready = (state == AR_IDLE);
  assign accept     = ctrl_valid & stat_ready;

  // Whole bursts and leftover beats
  assign full_bursts = ctrl_len[LOG_DATA_BYTES+LOG_BURST_LEN +: BURST_CNT_BITS];
  assign rem_beats   = ctrl_len[LOG_DATA_BYTES +: LOG_BURST_LEN];
  assign has_rem     = |rem_beats;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      start_r <= 1'b0;
      last_r  <= 1'b0;
    end else begin
      start_r <= accept;
      if (accept) begin
        last_r <= ctrl_last;
      end
    end
  end

  // Payload of the command, held until the next one
  always_ff @(posedge aclk) begin
    if (accept) begin
      final_idx_r <= has_rem ? full_bursts : full_bursts - 1'b1;
      final_len_r <= has_rem ? beats_t'(rem_beats - 1'b1) : beats_t'(`CDMA_BURST_LEN - 1);
      addr_r      <= ctrl_addr;
    end else if (arxfer) begin
      // Next burst starts one full burst later
      addr_r <= addr_r + addr_t'(BURST_BYTES);
    end
  end

  // Counter loads the final burst index one cycle after accept
  assign cnt_load  = start_r;
  assign cnt_value = final_idx_r;
  assign cnt_decr  = arxfer;

  ////////////////////////////////////////
  // Address channel FSM
  ////////////////////////////////////////

  assign arxfer = arvalid & arready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= AR_IDLE;
    end else begin
      case (state)
        AR_IDLE:  if (accept) state <= AR_WAIT;
        // Gap cycle, also holds off while too many bursts in flight
        AR_WAIT:  if (!q_full) state <= AR_VALID;
        AR_VALID: if (arready) state <= cnt_zero ? AR_IDLE : AR_WAIT;
        default:  state <= AR_IDLE;
      endcase
    end
  end

  assign arvalid = (state == AR_VALID);
  assign araddr  = addr_r;
  // Short length only on the final burst
  assign arlen   = cnt_zero ? final_len_r : beats_t'(`CDMA_BURST_LEN - 1);

  // One end flag per issued burst
  assign q_push = arxfer;
  assign q_flag = cnt_zero & last_r;

  ////////////////////////////////////////
  // Read data to stream
  ////////////////////////////////////////

  assign rready          = axis_out_tready;
  assign axis_out_tvalid = rvalid;
  assign axis_out_tkeep  = '1;
  assign rxfer           = rvalid & rready;

  // Burst retires on its rlast beat
  assign q_pop          = rxfer & rlast;
  assign axis_out_tlast = rvalid & rlast & q_head;
  assign stat_done      = q_pop & q_head;

endmodule

`default_nettype wire

// File: verilog/cdma_burst_queue.sv
/*
 * One-bit shift-register FIFO of per-burst end flags
 * Depth is the outstanding limit; head reads zero when empty
 * Push while full is dropped unless a pop happens in the same cycle
 */
`timescale 1ns/1ps
`include "cdma_consts.svh"

`default_nettype none

module cdma_burst_queue (
  input  wire  aclk,
  input  wire  aresetn,
  input  wire  push,
  input  wire  push_flag,
  input  wire  pop,
  output logic full,
  output logic head
);

  localparam int DEPTH = `CDMA_MAX_OUTSTANDING;
  localparam int CW    = $clog2(DEPTH + 1);
  localparam int IW    = $clog2(DEPTH);

  // Newest entry at index 0, oldest at count-1
  logic [DEPTH-1:0] flags;
  logic [CW-1:0]    count;
  logic [IW-1:0]    head_idx;
  logic             wr;
  logic             rd;
  logic             empty;

  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));

  // Qualified strobes
  assign wr = push & (~full | pop);
  assign rd = pop & ~empty;

  //////////////////////////////////////////
  // Storage
  //////////////////////////////////////////

  // Shift in on every write, no reset on payload
  always_ff @(posedge aclk) begin
    if (wr) begin
      flags <= {flags[DEPTH-2:0], push_flag};
    end
  end

  //////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count <= '0;
    end else if (wr && !rd) begin
      count <= count + 1'b1;
    end else if (rd && !wr) begin
      count <= count - 1'b1;
    end
  end

  // Oldest flag sits at the top of the filled region
  assign head_idx = IW'(count - 1'b1);
  assign head     = empty ? 1'b0 : flags[head_idx];

endmodule

`default_nettype wire

// File: verilog/cdma_burst_counter.sv
/*
 * Down-counter of bursts still to issue
 * Load takes priority over decrement; no wrap below zero
 */
`timescale 1ns/1ps
`include "cdma_consts.svh"

`default_nettype none

module cdma_burst_counter
  import cdma_pkg::*;
(
  input  wire        aclk,
  input  wire        aresetn,
  input  wire        load,
  input  burst_cnt_t load_value,
  input  wire        decr,
  output logic       is_zero
);

  // Bursts remaining after the one now on the bus
  burst_cnt_t count;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count <= '0;
    end else if (load) begin
      // Index of the final burst
      count <= load_value;
    end else if (decr && !is_zero) begin
      count <= count - 1'b1;
    end
  end

  // Zero marks the final burst of the command
  assign is_zero = (count == '0);

endmodule

`default_nettype wire

// File: verilog/cdma_pkg.sv
/*
 * Shared types for the aligned read engine
 * Widths follow the sizing macros, do not edit them here
 */
`include "cdma_consts.svh"

`default_nettype none

package cdma_pkg;

  // Beat and burst geometry
  localparam int DATA_BYTES     = `CDMA_DATA_BITS / 8;
  localparam int BURST_BYTES    = `CDMA_BURST_LEN * DATA_BYTES;
  localparam int LOG_DATA_BYTES = $clog2(DATA_BYTES);
  localparam int LOG_BURST_LEN  = $clog2(`CDMA_BURST_LEN);

  // Bits left for counting whole bursts in a command
  localparam int BURST_CNT_BITS = `CDMA_LEN_BITS - LOG_DATA_BYTES - LOG_BURST_LEN;

  typedef logic [`CDMA_ADDR_BITS-1:0] addr_t;
  typedef logic [`CDMA_LEN_BITS-1:0]  len_t;
  typedef logic [`CDMA_DATA_BITS-1:0] data_t;
  typedef logic [DATA_BYTES-1:0]      keep_t;
  typedef logic [7:0]                 beats_t;
  typedef logic [BURST_CNT_BITS-1:0]  burst_cnt_t;

  // Address channel sequencing
  typedef enum logic [1:0] {
    AR_IDLE,
    AR_WAIT,
    AR_VALID
  } ar_state_t;

endpackage

`default_nettype wire

// File: verilog/cdma_consts.svh
/*
 * Sizing macros for the aligned read engine
 * Burst length and data width must stay powers of two
 * Outstanding depth bounds the bursts in flight on the AR channel
 */
`ifndef CDMA_CONSTS_SVH
`define CDMA_CONSTS_SVH

`default_nettype none

// Beats in a full AXI burst
`define CDMA_BURST_LEN 16

// Data bus width, AXI read side and stream side
`define CDMA_DATA_BITS 64

// Byte address width
`define CDMA_ADDR_BITS 32

// Command length width, in bytes
`define CDMA_LEN_BITS 32

// Bursts allowed in flight before AR stalls
`define CDMA_MAX_OUTSTANDING 8

`default_nettype wire

`endif
